// ==== fetch_config.svh ====
// fetch configuration: widths, table size and reset address of the fetch stage
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// program counter width in bits
`define FETCH_PC_WIDTH 32

// table index width
// 5 bits gives 32 entries in both prediction tables
`define FETCH_INDEX_WIDTH 5

// first fetch address after reset
`define FETCH_START_ADDR 32'h0000_0100

// saturating counter width
// top bit is the taken prediction
`define FETCH_COUNTER_WIDTH 2

`endif

// ==== fetch_pkg.sv ====
// fetch package: shared fetch stage types and the saturating counter helpers
`include "fetch_config.svh"

package fetch_pkg;

    // program counter
    typedef logic [`FETCH_PC_WIDTH-1:0] fetch_pc_t;

    // table index, pc bits just above the byte offset
    typedef logic [`FETCH_INDEX_WIDTH-1:0] fetch_index_t;

    // pc bits above the index
    typedef logic [`FETCH_PC_WIDTH-`FETCH_INDEX_WIDTH-3:0] fetch_tag_t;

    typedef logic [`FETCH_COUNTER_WIDTH-1:0] fetch_counter_t;

    // redirect count, tags commands with the path they belong to
    typedef logic [3:0] fetch_jump_flag_t;

    typedef struct packed {
        logic valid;
        fetch_pc_t predicted_next;
        fetch_tag_t tag;
        logic jump_instruction;
    } fetch_target_entry_t;

    // instruction command payload
    typedef struct packed {
        fetch_pc_t pc;
        fetch_pc_t next_pc;
        fetch_jump_flag_t jump_flag;
        fetch_counter_t counter;
    } fetch_instruction_t;

    // jump command payload from execute
    typedef struct packed {
        fetch_pc_t current_pc;
        fetch_pc_t actual_next_pc;
        logic update_pc;
        logic branched;
        logic jumped;
        logic halt;
        fetch_counter_t counter;
    } fetch_jump_t;

    // taken when the top bit is set
    function automatic logic fetch_counter_taken(input fetch_counter_t value);
        return value[`FETCH_COUNTER_WIDTH-1];
    endfunction

    // one step toward the outcome, saturating at both ends
    function automatic fetch_counter_t fetch_counter_update(
        input fetch_counter_t value,
        input logic taken
    );
        fetch_counter_t result;
        result = value;
        if (taken && value != '1) begin
            result = fetch_counter_t'(value + 1'b1);
        end else if (!taken && value != '0) begin
            result = fetch_counter_t'(value - 1'b1);
        end
        return result;
    endfunction

endpackage

// ==== fetch_table_ram.sv ====
// fetch table ram: register array with combinational read and a clearing sweep after reset
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_table_ram #(
    parameter type T = logic,
    parameter int DEPTH = 1 << `FETCH_INDEX_WIDTH
) (
    input logic clk,
    input logic rst_n,
    input logic write_enable,
    input fetch_pkg::fetch_index_t write_index,
    input T write_data,
    output T write_read_data,
    input fetch_pkg::fetch_index_t read_index,
    output T read_data,
    output logic reset_done
);
    import fetch_pkg::*;

    T mem [DEPTH];

    // sweep state
    fetch_index_t sweep_index;
    logic sweeping;

    // sweep counter runs once per reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_index <= '0;
            sweeping <= 1'b1;
        end else if (sweeping) begin
            sweep_index <= fetch_index_t'(sweep_index + 1'b1);
            // last entry cleared on this edge
            if (sweep_index == fetch_index_t'(DEPTH - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    // array write port
    always_ff @(posedge clk) begin
        if (sweeping) begin
            // clear one entry per cycle
            mem[sweep_index] <= '0;
        end else if (write_enable) begin
            mem[write_index] <= write_data;
        end
    end

    // combinational reads
    // write side sees the value before this edge's write
    assign write_read_data = mem[write_index];
    assign read_data = mem[read_index];

    assign reset_done = !sweeping;

endmodule

// ==== fetch_jump_update.sv ====
// fetch jump update: turns jump commands into table writes, counter updates and halt
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_jump_update (
    input logic clk,
    input logic rst_n,
    input logic jump_valid,
    input fetch_pkg::fetch_pc_t jump_current_pc,
    input fetch_pkg::fetch_pc_t jump_actual_next_pc,
    input logic jump_branched,
    input logic jump_jumped,
    input logic jump_halt,
    input fetch_pkg::fetch_counter_t jump_counter,
    output logic target_write_enable,
    output fetch_pkg::fetch_index_t target_write_index,
    output fetch_pkg::fetch_target_entry_t target_write_data,
    output fetch_pkg::fetch_counter_t counter_write_data,
    output logic halt
);
    import fetch_pkg::*;

    // every jump command writes both tables
    // no back-pressure on this side
    assign target_write_enable = jump_valid;

    // index from pc bits above the byte offset
    assign target_write_index = jump_current_pc[`FETCH_INDEX_WIDTH+1:2];

    always_comb begin
        target_write_data.valid = 1'b1;
        // learned target is where execute actually went
        target_write_data.predicted_next = jump_actual_next_pc;
        // tag is everything above the index
        target_write_data.tag = jump_current_pc[`FETCH_PC_WIDTH-1:`FETCH_INDEX_WIDTH+2];
        // unconditional jumps predict taken regardless of the counter
        target_write_data.jump_instruction = jump_jumped;
    end

    // counter the command was predicted with, moved toward the outcome
    assign counter_write_data = fetch_counter_update(jump_counter, jump_branched);

    // sticky halt
    // only reset clears it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt <= 1'b0;
        end else if (jump_valid && jump_halt) begin
            halt <= 1'b1;
        end
    end

endmodule

// ==== fetch_predictor.sv ====
// fetch predictor: pc and jump flag registers, target and counter tables, next pc choice
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_predictor (
    input logic clk,
    input logic rst_n,
    input logic advance,
    input logic target_write_enable,
    input fetch_pkg::fetch_index_t target_write_index,
    input fetch_pkg::fetch_target_entry_t target_write_data,
    input fetch_pkg::fetch_counter_t counter_write_data,
    input logic redirect,
    input fetch_pkg::fetch_pc_t redirect_pc,
    output fetch_pkg::fetch_pc_t current_pc,
    output fetch_pkg::fetch_pc_t next_pc,
    output fetch_pkg::fetch_jump_flag_t jump_flag,
    output fetch_pkg::fetch_counter_t counter,
    output logic tables_ready
);
    import fetch_pkg::*;

    fetch_index_t read_index;
    fetch_target_entry_t target_entry;
    logic target_done;
    logic counter_done;
    logic table_hit;
    logic predicted_taken;
    fetch_jump_flag_t next_jump_flag;

    // both tables looked up at the current pc
    assign read_index = current_pc[`FETCH_INDEX_WIDTH+1:2];

    fetch_table_ram #(
        .T(fetch_target_entry_t)
    ) i_target_table (
        .clk(clk),
        .rst_n(rst_n),
        .write_enable(target_write_enable),
        .write_index(target_write_index),
        .write_data(target_write_data),
        .write_read_data(),
        .read_index(read_index),
        .read_data(target_entry),
        .reset_done(target_done)
    );

    // counter table shares the write index with the target table
    fetch_table_ram #(
        .T(fetch_counter_t)
    ) i_counter_table (
        .clk(clk),
        .rst_n(rst_n),
        .write_enable(target_write_enable),
        .write_index(target_write_index),
        .write_data(counter_write_data),
        .write_read_data(),
        .read_index(read_index),
        .read_data(counter),
        .reset_done(counter_done)
    );

    assign tables_ready = target_done && counter_done;

    always_comb begin
        // entry must be live and belong to this pc
        table_hit = target_entry.valid &&
            (target_entry.tag == current_pc[`FETCH_PC_WIDTH-1:`FETCH_INDEX_WIDTH+2]);
        predicted_taken = fetch_counter_taken(counter) || target_entry.jump_instruction;

        if (table_hit && predicted_taken) begin
            next_pc = target_entry.predicted_next;
        end else begin
            next_pc = current_pc + fetch_pc_t'(4);
        end

        // execute redirect wins over any prediction
        if (redirect) begin
            next_pc = redirect_pc;
            next_jump_flag = fetch_jump_flag_t'(jump_flag + 1'b1);
        end else begin
            next_jump_flag = jump_flag;
        end
    end

    // a redirect lands even while the outputs are stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_pc <= `FETCH_START_ADDR;
            jump_flag <= '0;
        end else if (advance || redirect) begin
            current_pc <= next_pc;
            jump_flag <= next_jump_flag;
        end
    end

endmodule

// ==== fetch_output_stage.sv ====
// fetch output stage: single entry valid/ready register slice
`timescale 1ns/1ns

module fetch_output_stage #(
    parameter type T = logic
) (
    input logic clk,
    input logic rst_n,
    input logic load,
    input T data_in,
    output logic can_accept,
    output logic valid,
    input logic ready,
    output T data
);

    // empty, or the held item leaves on this edge
    assign can_accept = !valid || ready;

    // occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (load) begin
            // refill, possibly in the same cycle as a transfer out
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    // payload holds until the next load
    always_ff @(posedge clk) begin
        if (load) begin
            data <= data_in;
        end
    end

endmodule

// ==== gecko_fetch.sv ====
// gecko fetch: instruction fetch stage with target table and counter based prediction
`timescale 1ns/1ns

module gecko_fetch (
    input logic clk,
    input logic rst_n,
    input logic jump_valid,
    input fetch_pkg::fetch_pc_t jump_current_pc,
    input fetch_pkg::fetch_pc_t jump_actual_next_pc,
    input logic jump_update_pc,
    input logic jump_branched,
    input logic jump_jumped,
    input logic jump_halt,
    input fetch_pkg::fetch_counter_t jump_counter,
    output logic cmd_valid,
    input logic cmd_ready,
    output fetch_pkg::fetch_instruction_t cmd_payload,
    output logic req_valid,
    input logic req_ready,
    output fetch_pkg::fetch_pc_t req_addr
);
    import fetch_pkg::*;

    logic target_write_enable;
    fetch_index_t target_write_index;
    fetch_target_entry_t target_write_data;
    fetch_counter_t counter_write_data;
    logic halt;
    logic redirect;
    logic advance;
    logic tables_ready;
    logic cmd_can_accept;
    logic req_can_accept;
    fetch_pc_t current_pc;
    fetch_pc_t next_pc;
    fetch_jump_flag_t jump_flag;
    fetch_counter_t counter;
    fetch_instruction_t next_command;

    fetch_jump_update i_jump_update (
        .clk(clk),
        .rst_n(rst_n),
        .jump_valid(jump_valid),
        .jump_current_pc(jump_current_pc),
        .jump_actual_next_pc(jump_actual_next_pc),
        .jump_branched(jump_branched),
        .jump_jumped(jump_jumped),
        .jump_halt(jump_halt),
        .jump_counter(jump_counter),
        .target_write_enable(target_write_enable),
        .target_write_index(target_write_index),
        .target_write_data(target_write_data),
        .counter_write_data(counter_write_data),
        .halt(halt)
    );

    // redirect only for commands that move the pc
    assign redirect = jump_valid && jump_update_pc;

    // produce when running and swept, and both slices have room
    assign advance = !halt && tables_ready && cmd_can_accept && req_can_accept;

    fetch_predictor i_predictor (
        .clk(clk),
        .rst_n(rst_n),
        .advance(advance),
        .target_write_enable(target_write_enable),
        .target_write_index(target_write_index),
        .target_write_data(target_write_data),
        .counter_write_data(counter_write_data),
        .redirect(redirect),
        .redirect_pc(jump_actual_next_pc),
        .current_pc(current_pc),
        .next_pc(next_pc),
        .jump_flag(jump_flag),
        .counter(counter),
        .tables_ready(tables_ready)
    );

    // command carries the counter back so execute can return it
    always_comb begin
        next_command.pc = current_pc;
        next_command.next_pc = next_pc;
        next_command.jump_flag = jump_flag;
        next_command.counter = counter;
    end

    fetch_output_stage #(
        .T(fetch_instruction_t)
    ) i_cmd_stage (
        .clk(clk),
        .rst_n(rst_n),
        .load(advance),
        .data_in(next_command),
        .can_accept(cmd_can_accept),
        .valid(cmd_valid),
        .ready(cmd_ready),
        .data(cmd_payload)
    );

    // memory request sees the same pc sequence, drained at its own ready
    fetch_output_stage #(
        .T(fetch_pc_t)
    ) i_req_stage (
        .clk(clk),
        .rst_n(rst_n),
        .load(advance),
        .data_in(current_pc),
        .can_accept(req_can_accept),
        .valid(req_valid),
        .ready(req_ready),
        .data(req_addr)
    );

endmodule

// ==== tb_gecko_fetch.sv ====
// fetch stage testbench: random back-pressure, reference model, assertions and watchdog
`timescale 1ns/1ns
`include "fetch_config.svh"

module tb_gecko_fetch;
    import fetch_pkg::*;

    localparam int TEST_CYCLES = 600;
    localparam int SWEEP_CYCLES = 32;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic jump_valid = 1'b0;
    fetch_pc_t jump_current_pc = '0;
    fetch_pc_t jump_actual_next_pc = '0;
    logic jump_update_pc = 1'b0;
    logic jump_branched = 1'b0;
    logic jump_jumped = 1'b0;
    logic jump_halt = 1'b0;
    fetch_counter_t jump_counter = '0;
    logic cmd_valid;
    logic cmd_ready = 1'b0;
    fetch_instruction_t cmd_payload;
    logic req_valid;
    logic req_ready = 1'b0;
    fetch_pc_t req_addr;

    // reference model state
    logic model_valid [32];
    fetch_pc_t model_target [32];
    logic [24:0] model_tag [32];
    logic model_jump [32];
    logic [1:0] model_counter [32];
    fetch_pc_t exp_pc = `FETCH_START_ADDR;
    logic [3:0] exp_flag = '0;
    fetch_pc_t cmd_pcs [$];
    fetch_pc_t req_addrs [$];

    // model view taken when a command first shows up
    logic cmd_pending = 1'b0;
    fetch_pc_t snap_next;
    logic [1:0] snap_counter;

    // rising edges since reset release
    int edges_after_reset = 0;

    // monitor flags
    logic first_seen = 1'b0;
    fetch_pc_t first_pc;
    logic [3:0] first_flag;
    logic seen_new = 1'b0;
    fetch_pc_t new_pc;
    fetch_pc_t watch_pc = '1;
    logic watch_seen = 1'b0;
    logic halt_sent = 1'b0;
    logic halt_drained = 1'b0;
    int post_halt_cmds = 0;
    int post_halt_reqs = 0;

    logic random_ready = 1'b0;
    logic [31:0] rand_state = 32'hbe02;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    string current_test = "reset";

    gecko_fetch i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // next pc from the model tables
    function automatic fetch_pc_t predict(input fetch_pc_t pc);
        logic [4:0] idx;
        idx = pc[6:2];
        if (model_valid[idx] && model_tag[idx] == pc[31:7] &&
            (model_counter[idx][1] || model_jump[idx])) begin
            return model_target[idx];
        end
        return pc + 32'd4;
    endfunction

    task automatic check_value(input string what, input fetch_pc_t expected,
                               input fetch_pc_t actual);
        assert (expected == actual) else begin
            errors++;
            $display("error %s %s expected %h actual %h", current_test, what, expected, actual);
        end
    endtask

    // ready inputs, random or held high
    always @(posedge clk) begin
        #5;
        rand_state = xorshift(rand_state);
        cmd_ready <= random_ready ? (rand_state[1:0] != 2'b00) : 1'b1;
        req_ready <= random_ready ? (rand_state[3:2] != 2'b00) : 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n) edges_after_reset <= edges_after_reset + 1;
    end

    // transfers seen at the falling edge, where everything is stable
    always @(negedge clk) begin
        if (rst_n && cmd_valid && !cmd_pending) begin
            // loaded on the last rising edge, from the tables as they were then
            snap_next = predict(cmd_payload.pc);
            snap_counter = model_counter[cmd_payload.pc[6:2]];
        end
        if (rst_n && cmd_valid && cmd_ready) begin
            if (halt_sent) post_halt_cmds++;
            cmd_pcs.push_back(cmd_payload.pc);
            if (!first_seen) begin
                first_seen = 1'b1;
                first_pc = cmd_payload.pc;
                first_flag = cmd_payload.jump_flag;
            end
            check_value("cmd counter", fetch_pc_t'(snap_counter),
                        fetch_pc_t'(cmd_payload.counter));
            if (cmd_payload.jump_flag == exp_flag) begin
                if (!seen_new) begin
                    seen_new = 1'b1;
                    new_pc = cmd_payload.pc;
                end
                if (cmd_payload.pc == watch_pc) watch_seen = 1'b1;
                check_value("cmd pc", exp_pc, cmd_payload.pc);
                check_value("cmd next_pc", snap_next, cmd_payload.next_pc);
                exp_pc = snap_next;
            end else begin
                // older path still draining
                assert (cmd_payload.jump_flag == 4'(exp_flag - 1'b1)) else begin
                    errors++;
                    $display("%s: command carries a jump flag from no known path", current_test);
                end
            end
        end
        cmd_pending = rst_n && cmd_valid && !cmd_ready;
        if (rst_n && req_valid && req_ready) begin
            if (halt_sent) post_halt_reqs++;
            req_addrs.push_back(req_addr);
        end
        while (cmd_pcs.size() > 0 && req_addrs.size() > 0) begin
            check_value("req_addr", cmd_pcs.pop_front(), req_addrs.pop_front());
        end
    end

    // held outputs keep their payload until taken
    cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_payload)))
        else begin
            errors++;
            $display("%s: command dropped or changed while stalled", current_test);
        end

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req_addr)))
        else begin
            errors++;
            $display("%s: request dropped or changed while stalled", current_test);
        end

    // valids stay low through the sweep and up to the first load
    sweep_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (edges_after_reset <= SWEEP_CYCLES) |-> (!cmd_valid && !req_valid))
        else begin
            errors++;
            $display("%s: output valid during the table sweep", current_test);
        end

    halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        halt_drained |-> (!cmd_valid && !req_valid))
        else begin
            errors++;
            $display("%s: output valid after halt drained", current_test);
        end

    // one jump command strobe, model tables follow once the write edge has passed
    task automatic send_jump(input fetch_pc_t cur, input fetch_pc_t nxt, input logic upd,
                             input logic br, input logic jmp, input logic hlt,
                             input logic [1:0] cnt);
        logic [4:0] idx;
        logic [1:0] c;
        @(posedge clk);
        #5;
        jump_valid = 1'b1;
        jump_current_pc = cur;
        jump_actual_next_pc = nxt;
        jump_update_pc = upd;
        jump_branched = br;
        jump_jumped = jmp;
        jump_halt = hlt;
        jump_counter = cnt;
        if (upd) begin
            exp_pc = nxt;
            exp_flag = exp_flag + 4'd1;
            seen_new = 1'b0;
        end
        if (hlt) halt_sent = 1'b1;
        @(posedge clk);
        #5;
        jump_valid = 1'b0;
        // items loaded on the write edge still read the old entries
        @(negedge clk);
        #1;
        idx = cur[6:2];
        c = cnt;
        if (br && c != 2'b11) c = c + 2'd1;
        else if (!br && c != 2'b00) c = c - 2'd1;
        model_valid[idx] = 1'b1;
        model_target[idx] = nxt;
        model_tag[idx] = cur[31:7];
        model_jump[idx] = jmp;
        model_counter[idx] = c;
    endtask

    task automatic wait_new_path(input int limit);
        int n;
        n = 0;
        while (!seen_new && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!seen_new) begin
            errors++;
            $display("%s: no command arrived on the redirected path", current_test);
        end
    endtask

    task automatic wait_watch(input int limit);
        int n;
        n = 0;
        while (!watch_seen && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!watch_seen) begin
            errors++;
            $display("%s: predicted target %h was never fetched", current_test, watch_pc);
        end
    endtask

    task automatic end_test(input int start_errors);
        tests_run++;
        if (errors != start_errors) tests_failed++;
        $display("test %s: %s", current_test, errors == start_errors ? "ok" : "FAILED");
    endtask

    // watchdog sized from the test lengths
    initial begin
        #((TEST_CYCLES + SWEEP_CYCLES) * 40);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int start;
        int n;
        for (int i = 0; i < 32; i++) begin
            model_valid[i] = 1'b0;
            model_target[i] = '0;
            model_tag[i] = '0;
            model_jump[i] = 1'b0;
            model_counter[i] = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        current_test = "reset_start";
        start = errors;
        n = 0;
        while (!first_seen && n < SWEEP_CYCLES + 20) begin
            @(posedge clk);
            n++;
        end
        if (!first_seen) begin
            errors++;
            $display("%s: no command after the sweep", current_test);
        end else begin
            check_value("first pc", `FETCH_START_ADDR, first_pc);
            check_value("first jump_flag", fetch_pc_t'(0), fetch_pc_t'(first_flag));
        end
        repeat (30) @(posedge clk);
        end_test(start);

        current_test = "back_pressure";
        start = errors;
        random_ready = 1'b1;
        repeat (200) @(posedge clk);
        random_ready = 1'b0;
        end_test(start);

        current_test = "redirect";
        start = errors;
        send_jump(32'h0000_4010, 32'h0000_0800, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0);
        wait_new_path(50);
        if (seen_new) check_value("redirect pc", 32'h0000_0800, new_pc);
        repeat (20) @(posedge clk);
        end_test(start);

        current_test = "prediction";
        start = errors;
        send_jump(32'h0000_2000, 32'h0000_5000, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0);
        send_jump(32'h0000_3008, 32'h0000_6000, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0);
        send_jump(32'h0000_3008, 32'h0000_6000, 1'b0, 1'b1, 1'b0, 1'b0, 2'd1);
        watch_pc = 32'h0000_5000;
        watch_seen = 1'b0;
        send_jump(32'h0000_4010, 32'h0000_2000, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0);
        wait_watch(50);
        watch_pc = 32'h0000_6000;
        watch_seen = 1'b0;
        send_jump(32'h0000_4010, 32'h0000_3008, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0);
        wait_watch(50);
        repeat (10) @(posedge clk);
        end_test(start);

        current_test = "halt";
        start = errors;
        send_jump(32'h0000_4010, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 2'd0);
        repeat (10) @(posedge clk);
        #5;
        halt_drained = 1'b1;
        repeat (20) @(posedge clk);
        assert (post_halt_cmds <= 2 && post_halt_reqs <= 2) else begin
            errors++;
            $display("%s: more than two items left after halt", current_test);
        end
        end_test(start);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== gecko_fetch.f ====
+incdir+.
fetch_pkg.sv
fetch_table_ram.sv
fetch_jump_update.sv
fetch_predictor.sv
fetch_output_stage.sv
gecko_fetch.sv
tb_gecko_fetch.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f gecko_fetch.f --top-module tb_gecko_fetch &&
./obj_dir/Vtb_gecko_fetch | tee /dev/stderr | grep -q "Verification passed" &&
echo "simulation run: pass" ||
{ echo "simulation run: fail"; exit 1; }
